// File: rs_params.svh
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// station depth, power of two so the ring pointers wrap
`define RS_DEPTH 8

// tag space must exceed the number of results in flight
`define TAG_WIDTH 4

`define XLEN 32

`define NUM_REGS 32

`endif

// File: rv32i_types_pkg.sv
`include "rs_params.svh"

package rv32i_types_pkg;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // register-immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // one instruction word, two decodings
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_word_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // value once ready, otherwise the tag of its producer
    typedef struct packed {
        logic                  ready;
        logic [`TAG_WIDTH-1:0] tag;
        logic [`XLEN-1:0]      data;
    } operand_t;

    typedef struct packed {
        logic                  valid;
        logic                  issued;
        logic [`TAG_WIDTH-1:0] tag;
        logic [4:0]            rd;
        alu_op_e               op;
        operand_t              src1;
        operand_t              src2;
    } rs_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [`TAG_WIDTH-1:0] tag;
        logic [4:0]            rd;
        logic [`XLEN-1:0]      data;
    } cdb_t;

endpackage

// File: dispatch_unit.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module dispatch_unit
    import rv32i_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        instr_valid,
    input  instr_word_u instr,
    input  logic        rs_available,
    input  cdb_t        cdb,
    output rs_entry_t   new_entry,
    output logic        stall
);
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic [`XLEN-1:0]      regs    [`NUM_REGS];
    logic [`TAG_WIDTH-1:0] reg_tag [`NUM_REGS];
    logic [`NUM_REGS-1:0]  busy;
    logic [`TAG_WIDTH-1:0] tag_cnt;

    logic       is_op;
    logic       is_op_imm;
    logic       alt_bit;
    logic       accept;
    logic       cdb_hit;
    alu_op_e    op;
    logic [4:0] rd;
    logic [`XLEN-1:0] imm;

    // register read with bypass from the broadcast of this cycle
    function automatic operand_t read_src(input logic [4:0] idx);
        operand_t s;
        s.ready = 1'b1;
        s.tag   = '0;
        s.data  = '0;
        if (idx == 5'd0) begin
            s.data = '0;
        end else if (busy[idx]) begin
            s.tag = reg_tag[idx];
            if (cdb.valid && cdb.tag == reg_tag[idx]) begin
                s.data = cdb.data;
            end else begin
                s.ready = 1'b0;
            end
        end else begin
            s.data = regs[idx];
        end
        return s;
    endfunction

    assign is_op     = (instr.r_view.opcode == OPC_OP);
    assign is_op_imm = (instr.i_view.opcode == OPC_OP_IMM);
    // bit 30 picks SUB / SRA
    assign alt_bit   = is_op ? instr.r_view.funct7[5] : instr.i_view.imm12[10];
    assign rd        = is_op ? instr.r_view.rd : instr.i_view.rd;
    assign imm       = {{(`XLEN-12){instr.i_view.imm12[11]}}, instr.i_view.imm12};

    assign stall  = !rs_available;
    assign accept = instr_valid && rs_available && !flush;

    always_comb begin
        unique case (instr.i_view.funct3)
            3'b000:  op = (is_op && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
    end

    always_comb begin
        new_entry        = '0;
        new_entry.valid  = accept && (is_op || is_op_imm);
        new_entry.issued = 1'b0;
        new_entry.tag    = tag_cnt;
        new_entry.rd     = rd;
        new_entry.op     = op;
        new_entry.src1   = read_src(instr.i_view.rs1);
        if (is_op_imm) begin
            new_entry.src2.ready = 1'b1;
            new_entry.src2.tag   = '0;
            new_entry.src2.data  = imm;
        end else begin
            new_entry.src2 = read_src(instr.r_view.rs2);
        end
    end

    // broadcast still belongs to the latest writer of rd
    assign cdb_hit = cdb.valid && (cdb.rd != 5'd0) && busy[cdb.rd]
                     && (reg_tag[cdb.rd] == cdb.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb_hit) begin
            regs[cdb.rd] <= cdb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy    <= '0;
            tag_cnt <= '0;
        end else begin
            if (cdb_hit) begin
                busy[cdb.rd] <= 1'b0;
            end
            // a new writer overrides a release of the same register
            if (new_entry.valid && rd != 5'd0) begin
                busy[rd]    <= 1'b1;
                reg_tag[rd] <= tag_cnt;
            end
            if (new_entry.valid) begin
                tag_cnt <= tag_cnt + 1'b1;
            end
        end
    end

endmodule

// File: reservation_station.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module reservation_station
    import rv32i_types_pkg::*;
#(
    parameter int DEPTH = `RS_DEPTH
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  rs_entry_t new_entry,
    input  cdb_t      cdb,
    output logic      rs_available,
    output rs_entry_t next_execute
);
    localparam int PTR_W = $clog2(DEPTH);

    rs_entry_t        stations [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic             full;
    logic [PTR_W:0]   count;

    logic             push;
    logic             pop;
    logic             head_free;
    logic [DEPTH-1:0] release_hit;
    logic             sel_found;
    logic [PTR_W-1:0] sel_idx;

    // span from head to tail, holes included
    assign count        = full ? (PTR_W+1)'(DEPTH) : {1'b0, tail - head};
    assign rs_available = (count != (PTR_W+1)'(DEPTH));

    // entries whose own result is on the bus this cycle
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            release_hit[i] = stations[i].valid && stations[i].issued
                             && cdb.valid && (cdb.tag == stations[i].tag);
        end
    end

    assign head_free = !stations[head].valid || release_hit[head];
    assign push      = new_entry.valid && rs_available;
    assign pop       = (count != '0) && head_free;

    // oldest ready entry, scanning from head
    always_comb begin
        logic [PTR_W-1:0] idx;
        sel_found    = 1'b0;
        sel_idx      = head;
        next_execute = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = head + PTR_W'(i);
            if (!sel_found && ((PTR_W+1)'(i) < count)
                && stations[idx].valid && !stations[idx].issued
                && stations[idx].src1.ready && stations[idx].src2.ready) begin
                sel_found = 1'b1;
                sel_idx   = idx;
            end
        end
        if (sel_found) begin
            next_execute = stations[sel_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            full <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                stations[i].valid  <= 1'b0;
                stations[i].issued <= 1'b0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                // wakeup of waiting operands
                if (stations[i].valid) begin
                    if (cdb.valid && !stations[i].src1.ready
                        && stations[i].src1.tag == cdb.tag) begin
                        stations[i].src1.ready <= 1'b1;
                        stations[i].src1.data  <= cdb.data;
                    end
                    if (cdb.valid && !stations[i].src2.ready
                        && stations[i].src2.tag == cdb.tag) begin
                        stations[i].src2.ready <= 1'b1;
                        stations[i].src2.data  <= cdb.data;
                    end
                end
                if (release_hit[i]) begin
                    stations[i].valid <= 1'b0;
                end
            end

            if (sel_found) begin
                stations[sel_idx].issued <= 1'b1;
            end

            // tail slot is free whenever push is allowed
            if (push) begin
                stations[tail] <= new_entry;
                tail           <= tail + 1'b1;
            end

            if (pop) begin
                head <= head + 1'b1;
            end

            if (pop) begin
                full <= 1'b0;
            end else if (push && (tail + 1'b1 == head)) begin
                full <= 1'b1;
            end
        end
    end

endmodule

// File: alu_unit.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module alu_unit
    import rv32i_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  rs_entry_t next_execute,
    output cdb_t      cdb
);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;

    assign a     = next_execute.src1.data;
    assign b     = next_execute.src2.data;
    // only the low five bits shift on RV32
    assign shamt = b[4:0];

    always_comb begin
        result = '0;
        unique case (next_execute.op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_SLT:  result[0] = ($signed(a) < $signed(b));
            ALU_SLTU: result[0] = (a < b);
            default:  result = a + b;
        endcase
    end

    // one cycle from issue to broadcast
    always_ff @(posedge clk) begin
        cdb.tag  <= next_execute.tag;
        cdb.rd   <= next_execute.rd;
        cdb.data <= result;
        if (rst || flush) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= next_execute.valid;
        end
    end

endmodule

// File: issue_top.sv
`timescale 1ns/1ps

module issue_top
    import rv32i_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  instr_word_u instr,
    input  logic        flush,
    output logic        stall,
    output cdb_t        cdb
);
    rs_entry_t new_entry;
    rs_entry_t next_execute;
    logic      rs_available;

    dispatch_unit dispatch_unit_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rs_available (rs_available),
        .cdb          (cdb),
        .new_entry    (new_entry),
        .stall        (stall)
    );

    reservation_station reservation_station_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .new_entry    (new_entry),
        .cdb          (cdb),
        .rs_available (rs_available),
        .next_execute (next_execute)
    );

    // single result source drives the whole bus
    alu_unit alu_unit_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .next_execute (next_execute),
        .cdb          (cdb)
    );

endmodule

// File: issue_sva.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module issue_sva
    import rv32i_types_pkg::*;
(
    input logic                          clk,
    input logic                          rst,
    input logic                          flush,
    input logic                          rs_available,
    input rs_entry_t                     next_execute,
    input rs_entry_t                     stations [`RS_DEPTH],
    input cdb_t                          cdb
);
    logic dup_tag;
    int   live_count;

    // any two live entries sharing a tag
    always_comb begin
        dup_tag    = 1'b0;
        live_count = 0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (stations[i].valid) begin
                live_count = live_count + 1;
            end
            for (int j = i + 1; j < `RS_DEPTH; j++) begin
                if (stations[i].valid && stations[j].valid
                    && stations[i].tag == stations[j].tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    // an issued entry must not be shown again
    no_reissue: assert property (@(posedge clk) disable iff (rst)
        next_execute.valid |=> !(next_execute.valid
                                 && next_execute.tag == $past(next_execute.tag)))
        else $error("entry issued twice");

    full_blocks: assert property (@(posedge clk) disable iff (rst)
        (live_count == `RS_DEPTH) |-> !rs_available)
        else $error("all entries live but station still available");

    unique_tags: assert property (@(posedge clk) disable iff (rst) !dup_tag)
        else $error("two live entries share a tag");

    flush_quiet: assert property (@(posedge clk) disable iff (rst) flush |=> !cdb.valid)
        else $error("broadcast after flush");

endmodule

bind reservation_station issue_sva issue_sva_i (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .rs_available (rs_available),
    .next_execute (next_execute),
    .stations     (stations),
    .cdb          (cdb)
);

// File: issue_tb.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module issue_tb
    import rv32i_types_pkg::*;
;
    localparam int          WAIT_LIMIT = 300;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    instr_word_u instr;
    logic        flush;
    logic        stall;
    cdb_t        cdb;

    // in-order model state
    logic [31:0]           model_regs [32];
    cdb_t                  expected   [1 << `TAG_WIDTH];
    logic                  pending    [1 << `TAG_WIDTH];
    logic [`TAG_WIDTH-1:0] tag_next;
    int                    outstanding;
    int                    stall_cycles;
    int                    mismatch_count;
    int                    other_errors;
    logic [31:0]           rand_state;

    issue_top issue_top_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .stall       (stall),
        .cdb         (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    function automatic instr_word_u r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        instr_word_u w;
        w.r_view = '{f7, rs2, rs1, f3, rd, OPC_OP};
        return w;
    endfunction

    function automatic instr_word_u i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        instr_word_u w;
        w.i_view = '{imm, rs1, f3, rd, OPC_OP_IMM};
        return w;
    endfunction

    // RV32I semantics by funct3, alt selects SUB or SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic timeout_abort(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("errors: mismatches=%0d other=%0d", mismatch_count, other_errors + 1);
        $display("Verification failed");
        $finish;
    endtask

    task automatic check_cdb(input cdb_t got, input cdb_t exp);
        if (got.rd !== exp.rd) begin
            mismatch_count++;
            $display("mismatch at %0t: cdb.rd got %0d expected %0d", $time, got.rd, exp.rd);
        end
        if (got.data !== exp.data) begin
            mismatch_count++;
            $display("mismatch at %0t: cdb.data got %h expected %h", $time, got.data, exp.data);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: stall got %b expected %b", $time, got, exp);
        end
    endtask

    // every broadcast must match a pending expectation with its tag
    always @(negedge clk) begin
        if (!rst && cdb.valid) begin
            if (!pending[cdb.tag]) begin
                other_errors++;
                $display("error at %0t: broadcast with unexpected tag %0d", $time, cdb.tag);
            end else begin
                check_cdb(cdb, expected[cdb.tag]);
                pending[cdb.tag] = 1'b0;
                outstanding--;
            end
        end
    end

    // called at posedge plus 1 ns, returns at the same phase after accept
    task automatic send(input instr_word_u w);
        int   guard;
        logic is_op;
        logic [31:0] a;
        logic [31:0] b;
        cdb_t exp;
        instr       = w;
        instr_valid = 1'b1;
        guard       = 0;
        @(negedge clk);
        while (stall) begin
            stall_cycles++;
            guard++;
            if (guard > WAIT_LIMIT) begin
                timeout_abort("stall never released");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        is_op = (w.r_view.opcode == OPC_OP);
        if (is_op || w.i_view.opcode == OPC_OP_IMM) begin
            a = model_regs[w.r_view.rs1];
            b = is_op ? model_regs[w.r_view.rs2] : {{20{w.i_view.imm12[11]}}, w.i_view.imm12};
            exp.valid = 1'b1;
            exp.tag   = tag_next;
            exp.rd    = w.r_view.rd;
            exp.data  = alu_ref(w.r_view.funct3,
                                is_op ? w.r_view.funct7[5]
                                      : (w.r_view.funct3 == 3'b101 && w.i_view.imm12[10]),
                                a, b);
            if (pending[tag_next]) begin
                other_errors++;
                $display("error at %0t: tag %0d reused while in flight", $time, tag_next);
            end
            expected[tag_next] = exp;
            pending[tag_next]  = 1'b1;
            outstanding++;
            tag_next++;
            if (exp.rd != 5'd0) begin
                model_regs[exp.rd] = exp.data;
            end
        end
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while (outstanding != 0) begin
            guard++;
            if (guard > WAIT_LIMIT) begin
                timeout_abort("broadcasts missing while draining");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_independent();
        logic [2:0]  f3;
        logic [11:0] imm;
        for (int r = 1; r <= 10; r++) begin
            send(i_type(xorshift() % 4096, 5'd0, 3'b000, 5'(r)));
        end
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
            send(r_type(k >= 8 ? 7'h20 : 7'h00, 5'(1 + xorshift() % 10),
                        5'(1 + xorshift() % 10), f3, 5'(11 + k)));
        end
        // nine immediate forms, SRAI last
        for (int k = 0; k < 9; k++) begin
            f3 = (k < 8) ? 3'(k) : 3'b101;
            if (k == 1 || k == 5) begin
                imm = {7'h00, 5'(xorshift())};
            end else if (k == 8) begin
                imm = {7'h20, 5'(xorshift())};
            end else begin
                imm = 12'(xorshift());
            end
            send(i_type(imm, 5'(1 + xorshift() % 10), f3, 5'(21 + k)));
        end
        drain();
    endtask

    task automatic test_chains();
        for (int i = 0; i < 24; i++) begin
            if (i % 3 == 2) begin
                send(i_type(12'(xorshift()), 5'(1 + xorshift() % 10), 3'b100, 5'(21 + i % 4)));
            end else if (xorshift() % 2 == 0) begin
                send(i_type(12'(xorshift()), 5'd5, 3'b000, 5'd5));
            end else begin
                send(r_type(7'h20, 5'd7, 5'd5, 3'b000, 5'd5));
            end
        end
        drain();
        // read back architectural state
        for (int r = 1; r < 32; r++) begin
            send(r_type(7'h00, 5'd0, 5'(r), 3'b000, 5'(r)));
        end
        drain();
    endtask

    task automatic test_x0();
        send(i_type(12'd5, 5'd1, 3'b000, 5'd0));
        send(r_type(7'h00, 5'd2, 5'd3, 3'b100, 5'd0));
        send(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd8));
        send(i_type(12'hfff, 5'd0, 3'b000, 5'd9));
        send(r_type(7'h20, 5'd0, 5'd9, 3'b000, 5'd10));
        drain();
    endtask

    task automatic test_full();
        stall_cycles = 0;
        for (int i = 0; i < 20; i++) begin
            send(i_type(12'(xorshift()), 5'd12, 3'(i % 2 ? 3'b100 : 3'b000), 5'd12));
        end
        if (stall_cycles == 0) begin
            other_errors++;
            $display("error at %0t: station never filled", $time);
        end
        drain();
        @(negedge clk);
        check_stall(stall, 1'b0);
        @(posedge clk);
        #1;
    endtask

    task automatic test_flush();
        for (int i = 0; i < 6; i++) begin
            send(r_type(7'h00, 5'(1 + i), 5'(2 + i), 3'b000, 5'(20 + i % 4)));
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        for (int t = 0; t < (1 << `TAG_WIDTH); t++) begin
            pending[t] = 1'b0;
        end
        outstanding = 0;
        tag_next    = '0;
        // monitor flags any broadcast from here on
        repeat (4) begin
            @(negedge clk);
            check_stall(stall, 1'b0);
        end
        @(posedge clk);
        #1;
        // load opcode is dropped without a tag
        send(32'h0000_2083);
        send(i_type(12'd7, 5'd1, 3'b000, 5'd24));
        send(r_type(7'h00, 5'd24, 5'd2, 3'b110, 5'd25));
        send(32'h0040_0063);
        send(r_type(7'h20, 5'd25, 5'd3, 3'b000, 5'd26));
        drain();
        repeat (6) @(posedge clk);
        #1;
    endtask

    initial begin
        rst            = 1'b1;
        instr_valid    = 1'b0;
        instr          = '0;
        flush          = 1'b0;
        rand_state     = 32'h87e83a31;
        tag_next       = '0;
        outstanding    = 0;
        stall_cycles   = 0;
        mismatch_count = 0;
        other_errors   = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int t = 0; t < (1 << `TAG_WIDTH); t++) begin
            pending[t] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_stall(stall, 1'b0);
        @(posedge clk);
        #1;
        test_independent();
        test_chains();
        test_x0();
        test_full();
        test_flush();
        $display("errors: mismatches=%0d other=%0d", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
rv32i_types_pkg.sv
dispatch_unit.sv
reservation_station.sv
alu_unit.sv
issue_top.sv
issue_sva.sv
issue_tb.sv

// File: run.sh
#!/bin/sh
# build and run the issue slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module issue_tb -o issue_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/issue_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0
